/* dcache.f */
+incdir+source
source/dcache_pkg.sv
source/burst_engine.sv
source/dcache_control.sv
source/line_data.sv
source/lru_table.sv
source/tag_store.sv
source/dcache_top.sv
tb/mem_model.sv
tb/dcache_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f dcache.f --top-module dcache_tb --Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vdcache_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
fi
exit 1

/* tb/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
();

    localparam int mem_words = 1024;
    localparam int stall_seed = 32'h3d75_fb3d;
    localparam int stall_pct = 25;

    typedef struct packed {
        logic wr;
        addr_t addr;
        strobe_t strobe;
        word_t data;
        int n_wb;
        int n_rf;
        addr_t wb_addr;
        logic chk;
        addr_t chk_addr;
        word_t exp;
        word_t chk_data;
    } test_entry_t;

    logic clk;
    logic reset;
    dbus_req_t dreq;
    dbus_resp_t dresp;
    cbus_req_t creq;
    cbus_resp_t cresp;

    test_entry_t tbl [$];
    cbus_req_t burst_q [$];
    word_t golden [mem_words];
    int wb_seen;
    int rf_seen;
    logic tbl_ready = 1'b0;

    dcache_top uut (
        .clk   (clk),
        .reset (reset),
        .dreq  (dreq),
        .dresp (dresp),
        .creq  (creq),
        .cresp (cresp)
    );

    mem_model #(
        .stall_seed (stall_seed),
        .stall_pct  (stall_pct),
        .mem_words  (mem_words)
    ) u_mem (
        .clk   (clk),
        .reset (reset),
        .creq  (creq),
        .cresp (cresp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int word_index(addr_t a);
        return int'((a >> 3) % mem_words);
    endfunction

    // 16 words of 8 bytes per line
    function automatic addr_t line_base(addr_t a);
        return {a[63:7], 7'd0};
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t wdata, strobe_t strobe);
        word_t res;
        res = old;
        for (int b = 0; b < 8; b++) begin
            if (strobe[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic stop_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_burst(cbus_req_t got, cbus_req_t exp);
        if (got.addr !== exp.addr || got.is_write !== exp.is_write) begin
            $display("MISMATCH at %0t ns: creq got addr %h write %0b expected addr %h write %0b",
                     $time, got.addr, got.is_write, exp.addr, exp.is_write);
            stop_with_failure();
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            $display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic add_read(addr_t addr, int n_wb, int n_rf, addr_t wb_addr);
        test_entry_t e;
        e = '0;
        e.addr = addr;
        e.n_wb = n_wb;
        e.n_rf = n_rf;
        e.wb_addr = wb_addr;
        tbl.push_back(e);
    endtask

    task automatic add_write(addr_t addr, strobe_t strobe, word_t data, int n_rf);
        test_entry_t e;
        e = '0;
        e.wr = 1'b1;
        e.addr = addr;
        e.strobe = strobe;
        e.data = data;
        e.n_rf = n_rf;
        tbl.push_back(e);
    endtask

    // memory word to compare once the last entry has finished
    task automatic expect_mem_word(addr_t addr);
        test_entry_t e;
        e = tbl.pop_back();
        e.chk = 1'b1;
        e.chk_addr = addr;
        tbl.push_back(e);
    endtask

    task automatic build_table();
        // set 1: cold miss, hits, partial write
        add_read(64'h0088, 0, 1, '0);
        add_read(64'h00f8, 0, 0, '0);
        add_write(64'h0090, 8'h0f, 64'h1122_3344_5566_7788, 0);
        add_read(64'h0090, 0, 0, '0);
        // set 0: A, B, A, then C replaces B
        add_read(64'h0000, 0, 1, '0);
        add_read(64'h0208, 0, 1, '0);
        add_read(64'h0010, 0, 0, '0);
        add_read(64'h0400, 0, 1, '0);
        add_read(64'h0018, 0, 0, '0);
        add_read(64'h0200, 0, 1, '0);
        // dirty A gets evicted by C
        add_write(64'h0020, 8'hff, 64'hdead_beef_cafe_f00d, 0);
        add_read(64'h0210, 0, 0, '0);
        add_read(64'h0408, 1, 1, 64'h0000);
        expect_mem_word(64'h0020);
        add_read(64'h0020, 0, 1, '0);
        // set 1: partially written line goes back to memory
        add_read(64'h0280, 0, 1, '0);
        add_read(64'h0488, 1, 1, 64'h0080);
        expect_mem_word(64'h0090);
        add_read(64'h0090, 0, 1, '0);
        add_write(64'h0498, 8'hc3, 64'h0102_0304_0506_0708, 0);
        // write miss allocates
        add_write(64'h0318, 8'hf0, 64'h8899_aabb_ccdd_eeff, 1);
        add_read(64'h0318, 0, 0, '0);
    endtask

    task automatic prepare_expected();
        test_entry_t e;
        for (int i = 0; i < mem_words; i++) begin
            golden[i] = u_mem.words[i];
        end
        for (int i = 0; i < tbl.size(); i++) begin
            e = tbl[i];
            if (e.chk) begin
                e.chk_data = golden[word_index(e.chk_addr)];
            end
            e.exp = merge_bytes(golden[word_index(e.addr)], e.data, e.strobe);
            golden[word_index(e.addr)] = e.exp;
            tbl[i] = e;
        end
    endtask

    task automatic note_burst(cbus_req_t got);
        cbus_req_t exp;
        if (burst_q.size() == 0) begin
            $display("ERROR: unexpected memory burst at %0t ns to %h", $time, got.addr);
            stop_with_failure();
        end else begin
            exp = burst_q.pop_front();
            check_burst(got, exp);
            if (got.is_write) begin
                wb_seen++;
            end else begin
                rf_seen++;
            end
        end
    endtask

    task automatic run_entry(test_entry_t e);
        cbus_req_t b;
        int waits;
        @(posedge clk);
        dreq.valid <= 1'b1;
        dreq.addr <= e.addr;
        dreq.strobe <= e.wr ? e.strobe : '0;
        dreq.data <= e.data;
        wb_seen = 0;
        rf_seen = 0;
        b = '0;
        if (e.n_wb > 0) begin
            b.is_write = 1'b1;
            b.addr = e.wb_addr;
            burst_q.push_back(b);
        end
        if (e.n_rf > 0) begin
            b.is_write = 1'b0;
            b.addr = line_base(e.addr);
            burst_q.push_back(b);
        end
        waits = 0;
        @(negedge clk);
        while (dresp.data_ok !== 1'b1) begin
            waits++;
            @(negedge clk);
        end
        check_count("dresp.addr_ok", int'(dresp.addr_ok), 1);
        check_word("dresp.data", dresp.data, e.exp);
        check_count("write-back bursts", wb_seen, e.n_wb);
        check_count("refill bursts", rf_seen, e.n_rf);
        if (e.n_wb == 0 && e.n_rf == 0) begin
            check_count("hit latency", waits, 2);
        end
        if (e.chk) begin
            check_word("memory word", u_mem.words[word_index(e.chk_addr)], e.chk_data);
        end
    endtask

    // new burst on each rising edge of creq.valid
    initial begin
        logic prev_valid;
        prev_valid = 1'b0;
        forever begin
            @(negedge clk);
            if (!reset && creq.valid === 1'b1 && prev_valid !== 1'b1) begin
                note_burst(creq);
            end
            prev_valid = creq.valid;
        end
    end

    initial begin
        int limit;
        wait (tbl_ready);
        limit = tbl.size() * 2 * (32 * 4) + 300;
        repeat (limit) @(posedge clk);
        $display("ERROR: cache stopped responding, run exceeded %0d cycles", limit);
        stop_with_failure();
    end

    initial begin
        dreq <= '0;
        reset <= 1'b1;
        build_table();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        prepare_expected();
        tbl_ready = 1'b1;
        foreach (tbl[i]) begin
            run_entry(tbl[i]);
        end
        @(posedge clk);
        dreq.valid <= 1'b0;
        repeat (4) @(posedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* tb/mem_model.sv */
`timescale 1ns/1ps

module mem_model
    import dcache_pkg::*;
#(
    parameter int stall_seed = 1,
    parameter int stall_pct = 25,
    parameter int mem_words = 1024
) (
    input  logic       clk,
    input  logic       reset,
    input  cbus_req_t  creq,
    output cbus_resp_t cresp
);

    localparam int aw = $clog2(mem_words);

    word_t words [mem_words];
    integer seed = stall_seed;
    offset_t count;

    // word address wraps inside the modelled space
    function automatic logic [aw-1:0] word_index(addr_t addr, offset_t ofs);
        return addr[aw+2:3] + aw'(ofs);
    endfunction

    // each word encodes its own byte address
    function automatic word_t fill_word(int i);
        logic [31:0] a;
        a = 32'(i) << 3;
        return {a ^ 32'h5a5a_0000, ~a};
    endfunction

    initial begin
        cresp <= '0;
        for (int i = 0; i < mem_words; i++) begin
            words[i] <= fill_word(i);
        end
    end

    always @(posedge clk) begin
        logic take;
        logic give;
        offset_t next_count;
        if (reset) begin
            cresp <= '0;
            count <= '0;
        end else begin
            take = creq.valid && cresp.ready;
            next_count = count;
            if (take) begin
                if (creq.is_write) begin
                    words[word_index(creq.addr, count)] <= creq.data;
                end
                next_count = cresp.last ? '0 : count + 1'b1;
            end
            // no ready right after the last beat, valid drops then
            give = creq.valid && !(take && cresp.last);
            give = give && (($unsigned($random(seed)) % 100) >= stall_pct);
            cresp.ready <= give;
            cresp.last <= give && (next_count == 4'd15);
            cresp.data <= words[word_index(creq.addr, next_count)];
            count <= next_count;
        end
    end

endmodule

/* source/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  dbus_req_t  dreq,
    output dbus_resp_t dresp,
    output cbus_req_t  creq,
    input  cbus_resp_t cresp
);

    dc_state_t state;
    logic hit;
    way_t hit_way;
    meta_t victim_meta;
    way_t victim_way;
    way_t sel_way;
    logic burst_start;
    logic burst_write;
    logic burst_done;
    logic meta_fill;
    logic meta_dirty;
    logic lru_touch;
    word_t rdata;
    offset_t beat;
    offset_t line_offset;
    logic fill_en;
    tag_t line_tag;

    // beat counter addresses the line while a burst runs
    assign line_offset = (state == WRITEBACK || state == REFILL) ? beat : get_offset(dreq.addr);
    // write-back goes to the victim's line, refill to the request's
    assign line_tag = (state == WRITEBACK) ? victim_meta.tag : get_tag(dreq.addr);

    dcache_control u_control (
        .clk         (clk),
        .reset       (reset),
        .dreq        (dreq),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_meta (victim_meta),
        .victim_way  (victim_way),
        .burst_done  (burst_done),
        .rdata       (rdata),
        .state       (state),
        .burst_start (burst_start),
        .burst_write (burst_write),
        .meta_fill   (meta_fill),
        .meta_dirty  (meta_dirty),
        .lru_touch   (lru_touch),
        .sel_way     (sel_way),
        .dresp       (dresp)
    );

    tag_store u_tags (
        .clk         (clk),
        .reset       (reset),
        .addr        (dreq.addr),
        .sel_way     (sel_way),
        .meta_fill   (meta_fill),
        .meta_dirty  (meta_dirty),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .victim_meta (victim_meta)
    );

    line_data u_data (
        .clk        (clk),
        .index      (get_index(dreq.addr)),
        .way        (sel_way),
        .offset     (line_offset),
        .fill_en    (fill_en),
        .fill_data  (cresp.data),
        .store_en   (meta_dirty),
        .strobe     (dreq.strobe),
        .store_data (dreq.data),
        .rdata      (rdata)
    );

    lru_table u_lru (
        .clk        (clk),
        .reset      (reset),
        .index      (get_index(dreq.addr)),
        .touch      (lru_touch),
        .used_way   (sel_way),
        .victim_way (victim_way)
    );

    burst_engine u_burst (
        .clk      (clk),
        .reset    (reset),
        .start    (burst_start),
        .write    (burst_write),
        .line_tag (line_tag),
        .index    (get_index(dreq.addr)),
        .cresp    (cresp),
        .wdata    (rdata),
        .creq     (creq),
        .beat     (beat),
        .fill_en  (fill_en),
        .done     (burst_done)
    );

endmodule

/* source/tag_store.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module tag_store
    import dcache_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  addr_t addr,
    input  way_t  sel_way,
    input  logic  meta_fill,
    input  logic  meta_dirty,
    output logic  hit,
    output way_t  hit_way,
    input  way_t  victim_way,
    output meta_t victim_meta
);

    meta_t meta [`DC_SETS][`DC_WAYS];
    index_t idx;
    tag_t tag;
    logic [`DC_WAYS-1:0] match;

    assign idx = get_index(addr);
    assign tag = get_tag(addr);

    // both ways compared at once
    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            match[w] = meta[idx][w].valid && (meta[idx][w].tag == tag);
        end
    end

    assign hit = |match;
    assign hit_way = way_t'(match[1]);
    assign victim_meta = meta[idx][victim_way];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                for (int w = 0; w < `DC_WAYS; w++) begin
                    meta[s][w].valid <= 1'b0;
                    meta[s][w].dirty <= 1'b0;
                end
            end
        end else if (meta_fill) begin
            // freshly refilled line is clean
            meta[idx][sel_way].valid <= 1'b1;
            meta[idx][sel_way].dirty <= 1'b0;
            meta[idx][sel_way].tag <= tag;
        end else if (meta_dirty) begin
            meta[idx][sel_way].dirty <= 1'b1;
        end
    end

endmodule

/* source/lru_table.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module lru_table
    import dcache_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  index_t index,
    input  logic   touch,
    input  way_t   used_way,
    output way_t   victim_way
);

    // way used last in each set
    logic [`DC_SETS-1:0] last_used;

    always_ff @(posedge clk) begin
        if (reset) begin
            // way 0 is the first victim everywhere
            last_used <= '1;
        end else if (touch) begin
            last_used[index] <= used_way;
        end
    end

    assign victim_way = ~last_used[index];

endmodule

/* source/line_data.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module line_data
    import dcache_pkg::*;
(
    input  logic    clk,
    input  index_t  index,
    input  way_t    way,
    input  offset_t offset,
    input  logic    fill_en,
    input  word_t   fill_data,
    input  logic    store_en,
    input  strobe_t strobe,
    input  word_t   store_data,
    output word_t   rdata
);

    localparam int DEPTH = `DC_SETS * `DC_WAYS * `DC_WORDS_PER_LINE;
    localparam int AW = `DC_INDEX_BITS + 1 + `DC_OFFSET_BITS;

    word_t mem [DEPTH];
    logic [AW-1:0] waddr;
    strobe_t wmask;
    word_t wdata;

    // set, then way, then word
    assign waddr = {index, way, offset};

    // refill beats write the whole word
    assign wmask = fill_en ? '1 : (store_en ? strobe : '0);
    assign wdata = fill_en ? fill_data : store_data;

    always_ff @(posedge clk) begin
        for (int b = 0; b < `DC_STRB_BITS; b++) begin
            if (wmask[b]) begin
                mem[waddr][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    // combinational read feeds dresp and write-back beats
    assign rdata = mem[waddr];

endmodule

/* source/dcache_control.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_control
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  dbus_req_t  dreq,
    input  logic       hit,
    input  way_t       hit_way,
    input  meta_t      victim_meta,
    input  way_t       victim_way,
    input  logic       burst_done,
    input  word_t      rdata,
    output dc_state_t  state,
    output logic       burst_start,
    output logic       burst_write,
    output logic       meta_fill,
    output logic       meta_dirty,
    output logic       lru_touch,
    output way_t       sel_way,
    output dbus_resp_t dresp
);

    dc_state_t next_state;
    logic start_q;
    word_t merged;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (dreq.valid) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    next_state = RESPOND;
                end else if (victim_meta.valid && victim_meta.dirty) begin
                    next_state = WRITEBACK;
                end else begin
                    next_state = REFILL;
                end
            end
            WRITEBACK: begin
                if (burst_done) begin
                    next_state = REFILL;
                end
            end
            REFILL: begin
                if (burst_done) begin
                    next_state = RESPOND;
                end
            end
            RESPOND: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            start_q <= 1'b0;
            sel_way <= '0;
        end else begin
            state <= next_state;
            // one start pulse in the first cycle of each burst state,
            // so creq.valid drops for a cycle between write-back and refill
            start_q <= (state == LOOKUP && !hit) || (state == WRITEBACK && burst_done);
            if (state == LOOKUP) begin
                sel_way <= hit ? hit_way : victim_way;
            end
        end
    end

    assign burst_start = start_q;
    assign burst_write = (state == WRITEBACK);
    assign meta_fill = (state == REFILL) && burst_done;
    assign meta_dirty = (state == RESPOND) && (|dreq.strobe);
    assign lru_touch = (state == RESPOND);

    // array still holds the old word in RESPOND, so return the merged one
    always_comb begin
        for (int i = 0; i < `DC_STRB_BITS; i++) begin
            merged[8*i +: 8] = dreq.strobe[i] ? dreq.data[8*i +: 8] : rdata[8*i +: 8];
        end
    end

    always_comb begin
        dresp.addr_ok = (state == RESPOND);
        dresp.data_ok = (state == RESPOND);
        dresp.data = merged;
    end

endmodule

/* source/burst_engine.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module burst_engine
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic       write,
    input  tag_t       line_tag,
    input  index_t     index,
    input  cbus_resp_t cresp,
    input  word_t      wdata,
    output cbus_req_t  creq,
    output offset_t    beat,
    output logic       fill_en,
    output logic       done
);

    logic busy;
    logic dir_q;
    offset_t beat_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            dir_q <= 1'b0;
            beat_q <= '0;
        end else if (start) begin
            busy <= 1'b1;
            dir_q <= write;
            beat_q <= '0;
        end else if (busy && cresp.ready) begin
            if (cresp.last) begin
                busy <= 1'b0;
                beat_q <= '0;
            end else begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    always_comb begin
        creq.valid = busy;
        creq.is_write = dir_q;
        // line base, word and byte bits zero
        creq.addr = {line_tag, index, {(`DC_OFFSET_BITS + `DC_BYTE_OFS_BITS){1'b0}}};
        creq.data = wdata;
    end

    assign beat = beat_q;
    assign fill_en = busy && !dir_q && cresp.ready;
    assign done = busy && cresp.ready && cresp.last;

endmodule

/* source/dcache_pkg.sv */
`include "dcache_defines.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_BITS-1:0] addr_t;
    typedef logic [`DC_WORD_BITS-1:0] word_t;
    typedef logic [`DC_STRB_BITS-1:0] strobe_t;
    typedef logic [`DC_OFFSET_BITS-1:0] offset_t;
    typedef logic [`DC_INDEX_BITS-1:0] index_t;
    typedef logic [`DC_TAG_BITS-1:0] tag_t;
    typedef logic way_t;

    // processor side, zero strobe is a read
    typedef struct packed {
        logic valid;
        addr_t addr;
        strobe_t strobe;
        word_t data;
    } dbus_req_t;

    typedef struct packed {
        logic addr_ok;
        logic data_ok;
        word_t data;
    } dbus_resp_t;

    // memory side, always 16-beat incrementing bursts
    typedef struct packed {
        logic valid;
        logic is_write;
        addr_t addr;
        word_t data;
    } cbus_req_t;

    typedef struct packed {
        logic ready;
        logic last;
        word_t data;
    } cbus_resp_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } meta_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        RESPOND
    } dc_state_t;

    function automatic tag_t get_tag(addr_t addr);
        return addr[`DC_ADDR_BITS-1 -: `DC_TAG_BITS];
    endfunction

    function automatic index_t get_index(addr_t addr);
        return addr[`DC_BYTE_OFS_BITS + `DC_OFFSET_BITS +: `DC_INDEX_BITS];
    endfunction

    function automatic offset_t get_offset(addr_t addr);
        return addr[`DC_BYTE_OFS_BITS +: `DC_OFFSET_BITS];
    endfunction

endpackage

/* source/dcache_defines.svh */
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// bus widths
`define DC_ADDR_BITS 64
`define DC_WORD_BITS 64
`define DC_STRB_BITS 8

// cache geometry
`define DC_WORDS_PER_LINE 16
`define DC_SETS 4
`define DC_WAYS 2

// address split, tag takes what is left above index
`define DC_BYTE_OFS_BITS 3
`define DC_OFFSET_BITS 4
`define DC_INDEX_BITS 2
`define DC_TAG_BITS (`DC_ADDR_BITS - `DC_INDEX_BITS - `DC_OFFSET_BITS - `DC_BYTE_OFS_BITS)

`endif
